// ==== hw/s16_settings.svh ====
`ifndef S16_SETTINGS_SVH
`define S16_SETTINGS_SVH

// cpu clock enable, 29/146 of clk
`define S16_CEN_NUM 29
`define S16_CEN_DEN 146
`define S16_CEN_W 8

// idle level of cabinet bytes and 8255 ports
`define S16_IO_RESET 8'hff
`define S16_PPI_CTRL_RESET 8'h80

// fields of the word address A[23:1]
`define S16_REGION 23:22
`define S16_BLOCK 18:16
`define S16_IO_SUB 13:12
`define S16_IO_PORT 2:1
`define S16_DIP_SEL 1

`define S16_FC_IACK 3'b111

`endif

// ==== hw/s16_pkg.sv ====
`default_nettype none

package s16_pkg;

    typedef struct packed {
        logic [23:1] addr;   // word address
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [2:0]  fc;
        logic [15:0] dout;   // write data from the master
    } cpu_bus_t;

    typedef struct packed {
        logic rom;
        logic char;
        logic obj;
        logic pal;
        logic io;
        logic wdog;
        logic vram;
        logic ram;
    } mem_sel_t;

    typedef struct packed {
        logic [7:0]  joy1;
        logic [7:0]  joy2;
        logic [7:0]  joy3;
        logic [7:0]  joy4;
        logic [15:0] ana1;
        logic [15:0] ana2;
        logic [3:0]  start;
        logic [1:0]  coin;
        logic        service;
        logic        test;
        logic [7:0]  dip_a;
        logic [7:0]  dip_b;
    } cab_in_t;

    typedef struct packed {
        logic [7:0] snd_latch;
        logic       snd_irq_n;
        logic       sound_en;
        logic       video_en;
        logic       flip;
        logic       colscr_en;
        logic       rowscr_en;
    } board_ctrl_t;

    typedef enum logic [7:0] {
        game_generic = 8'd0,
        game_sdi     = 8'd1,
        game_passsht = 8'd2
    } game_t;

    // 8255 control word, bit 7 picks the view
    typedef union packed {
        struct packed {
            logic       set;         // 1 for a mode word
            logic [1:0] grp_a_mode;
            logic       pa_in;
            logic       pch_in;      // port C upper nibble
            logic       grp_b_mode;
            logic       pb_in;
            logic       pcl_in;      // port C lower nibble
        } mode;
        struct packed {
            logic       clr;         // zero here
            logic [2:0] spare;
            logic [2:0] bit_sel;
            logic       bit_val;
        } bsr;
    } ppi_word_u;

endpackage

`default_nettype wire

// ==== hw/s16_addr_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16_settings.svh"

module s16_addr_dec import s16_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  cpu_bus_t bus,
    output mem_sel_t sel,
    output logic     berr_n
);

logic       valid;    // memory cycle, iack is not decoded
logic       strobe;
logic [1:0] region;
logic [2:0] block;
mem_sel_t   hit;

always_comb begin
    region = bus.addr[`S16_REGION];
    block  = bus.addr[`S16_BLOCK];
    valid  = !bus.as_n && bus.fc != `S16_FC_IACK;
    strobe = !(bus.uds_n && bus.lds_n);

    hit.rom  = region == 2'd0 && !block[2];           // 00-03
    hit.char = region == 2'd1 && block == 3'd1;       // 41
    hit.obj  = region == 2'd1 && block[2];            // 44
    hit.pal  = region == 2'd2 && block[2];            // 84
    hit.io   = region == 2'd3 && block[2:1] == 2'b10; // c4
    hit.wdog = region == 2'd3 && block == 3'd6;       // c6

    // strobes drop between the read and write of a read-modify-write,
    // so these two selects toggle and the RAM controller sees two requests
    hit.vram = strobe && region == 2'd1 && block == 3'd0; // 40
    hit.ram  = strobe && region == 2'd3 && block == 3'd7; // c7
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        sel    <= '0;
        berr_n <= 1'b1;
    end else if (valid) begin
        sel    <= hit;
        berr_n <= !(strobe && hit == '0); // unmapped
    end else begin
        sel    <= '0;
        berr_n <= 1'b1;
    end
end

endmodule

`default_nettype wire

// ==== hw/s16_cab_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16_settings.svh"

module s16_cab_io import s16_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       io_sel,
    input  cpu_bus_t   bus,
    input  game_t      game,
    input  cab_in_t    cab,
    input  logic [7:0] ppi_dout,
    output logic       ppi_cs,
    output logic [7:0] cab_dout
);

localparam logic [7:0] io_idle = `S16_IO_RESET;

logic [1:0] io_sub, port;
logic [7:0] sort1, sort2, pass_byte;
logic [1:0] port_cnt, pass_cnt; // passing shot player rotation
logic       last_io, ppi_cs_d;
logic       port_b2;            // copy of 8255 port B bit 2

function automatic logic [7:0] sort_joy(input logic [7:0] joy);
    return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
endfunction

function automatic logic [7:0] pass_joy(input logic [7:0] joy);
    return {joy[7:4], joy[1:0], joy[3:2]};
endfunction

// bit 2 switches to the other axis, negated
function automatic logic [7:0] sdi_joy(input logic [15:0] ana, input logic neg);
    return neg ? (~ana[15:8] + 8'd1) : ana[7:0];
endfunction

always_comb begin
    io_sub   = bus.addr[`S16_IO_SUB];
    port     = bus.addr[`S16_IO_PORT];
    sort1    = sort_joy(cab.joy1);
    sort2    = sort_joy(cab.joy2);
    pass_cnt = last_io ? port_cnt : port_cnt + 2'd1; // count after this access
    case (pass_cnt)
        2'd1:    pass_byte = pass_joy(cab.joy1);
        2'd2:    pass_byte = pass_joy(cab.joy2);
        2'd3:    pass_byte = pass_joy(cab.joy3);
        default: pass_byte = pass_joy(cab.joy4);
    endcase
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        cab_dout <= io_idle;
        ppi_cs   <= 1'b0;
        ppi_cs_d <= 1'b0;
        last_io  <= 1'b0;
        port_cnt <= 2'd0;
        port_b2  <= io_idle[2];
    end else begin
        last_io  <= io_sel;
        ppi_cs   <= io_sel && !last_io && io_sub == 2'd0; // once per bus cycle
        ppi_cs_d <= ppi_cs;
        // port B register read back after the access
        if (ppi_cs_d && port == 2'd1) port_b2 <= ppi_dout[2];
        cab_dout <= io_idle;
        if (io_sel) begin
            case (io_sub)
                2'd0: cab_dout <= ppi_dout;
                2'd1: begin
                    case (port)
                        2'd0: begin
                            if (!last_io) port_cnt <= 2'd0;
                            cab_dout <= {2'b11, cab.start[1:0], cab.service, cab.test, cab.coin};
                            if (game == game_sdi) begin
                                cab_dout[7:6] <= {cab.joy2[4], cab.joy1[4]}; // fire
                            end else if (game == game_passsht) begin
                                cab_dout[7:6] <= cab.start[3:2];
                            end
                        end
                        2'd1: begin
                            case (game)
                                game_sdi: cab_dout <= sdi_joy(cab.ana1, port_b2);
                                game_passsht: begin
                                    port_cnt <= pass_cnt;
                                    cab_dout <= pass_byte;
                                end
                                default: cab_dout <= sort1;
                            endcase
                        end
                        2'd2: if (game == game_sdi) cab_dout <= {sort2[7:4], sort1[7:4]};
                        default: begin
                            if (game == game_sdi) cab_dout <= sdi_joy(cab.ana2, port_b2);
                            else cab_dout <= sort2;
                        end
                    endcase
                end
                2'd2: cab_dout <= bus.addr[`S16_DIP_SEL] ? cab.dip_b : cab.dip_a;
                default: cab_dout <= io_idle;
            endcase
        end
    end
end

endmodule

`default_nettype wire

// ==== hw/s16_ppi.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16_settings.svh"

module s16_ppi import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cs,
    input  logic [1:0]  addr,
    input  logic        wr,
    input  logic [7:0]  din,
    input  logic        snd_ack,
    output logic [7:0]  dout,
    output board_ctrl_t ctrl,
    output logic [7:0]  port_b
);

localparam logic [7:0] io_idle = `S16_IO_RESET;

logic [7:0] pa_q, pb_q, pc_q;  // output latches
logic [7:0] pa_pin, pc_pin;
ppi_word_u  ctrl_q;
ppi_word_u  wr_word;

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        pa_q   <= io_idle;
        pb_q   <= io_idle;
        pc_q   <= io_idle;
        ctrl_q <= `S16_PPI_CTRL_RESET;
    end else if (cs && wr) begin
        case (addr)
            2'd0: pa_q <= din;
            2'd1: pb_q <= din;
            2'd2: pc_q <= din;
            default: begin
                if (wr_word.mode.set) begin
                    ctrl_q <= wr_word; // new mode clears every port
                    pa_q   <= 8'h00;
                    pb_q   <= 8'h00;
                    pc_q   <= 8'h00;
                end else begin
                    pc_q[wr_word.bsr.bit_sel] <= wr_word.bsr.bit_val;
                end
            end
        endcase
    end
end

// ports set as inputs float high on the board
always_comb begin
    wr_word = din;
    pa_pin  = ctrl_q.mode.pa_in ? 8'hff : pa_q;
    port_b  = ctrl_q.mode.pb_in ? 8'hff : pb_q;
    pc_pin  = {ctrl_q.mode.pch_in ? 4'hf : pc_q[7:4],
               ctrl_q.mode.pcl_in ? 4'hf : pc_q[3:0]};
    case (addr)
        2'd0:    dout = pa_pin;
        2'd1:    dout = port_b;
        2'd2:    dout = {pc_pin[7], snd_ack, pc_pin[5:0]}; // sound cpu ack
        default: dout = ctrl_q;
    endcase
end

always_comb begin
    ctrl.snd_latch = pa_pin;
    ctrl.snd_irq_n = pc_pin[7];
    ctrl.colscr_en = ~pc_pin[2];
    ctrl.rowscr_en = ~pc_pin[1];
    ctrl.flip      = port_b[7];
    ctrl.sound_en  = ~port_b[5]; // mute is active high
    ctrl.video_en  = port_b[4];
end

endmodule

`default_nettype wire

// ==== hw/s16_bus_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "s16_settings.svh"

module s16_bus_ctrl import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  cpu_bus_t    bus,
    input  logic        vint,
    input  mem_sel_t    sel,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_data,
    input  logic [15:0] pal_data,
    input  logic [15:0] obj_data,
    input  logic [7:0]  cab_dout,
    output logic        dtack_n,
    output logic        irq_n,
    output logic [15:0] din
);

localparam int             cen_w   = `S16_CEN_W;
localparam logic [cen_w:0] cen_num = `S16_CEN_NUM;
localparam logic [cen_w:0] cen_den = `S16_CEN_DEN;

logic [cen_w-1:0] cen_acc;
logic [cen_w:0]   cen_sum, cen_wrap;
logic             cen;
logic             bus_cs, bus_busy;
logic             cs_q;      // select already seen, read data settled
logic             inta, last_vint;

always_comb begin
    cen_sum  = {1'b0, cen_acc} + cen_num;
    cen_wrap = cen_sum - cen_den;
    bus_cs   = sel != '0;
    bus_busy = (sel.rom && !rom_ok) || ((sel.ram || sel.vram) && !ram_ok);
    inta     = bus.fc == `S16_FC_IACK && !bus.as_n;  // interrupt ack
end

// fractional divider
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        cen_acc <= '0;
        cen     <= 1'b0;
    end else if (cen_sum >= cen_den) begin
        cen_acc <= cen_wrap[cen_w-1:0];
        cen     <= 1'b1;
    end else begin
        cen_acc <= cen_sum[cen_w-1:0];
        cen     <= 1'b0;
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        cs_q    <= 1'b0;
        dtack_n <= 1'b1;
    end else begin
        cs_q <= bus_cs;
        if (bus.as_n) begin
            dtack_n <= 1'b1;
        end else if (cen && bus_cs && cs_q && !bus_busy) begin
            dtack_n <= 1'b0;
        end
    end
end

// vblank, edge triggered
always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        last_vint <= 1'b0;
        irq_n     <= 1'b1;
    end else begin
        last_vint <= vint;
        if (inta) irq_n <= 1'b1;
        else if (vint && !last_vint) irq_n <= 1'b0;
    end
end

always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
        din <= 16'hffff;
    end else if (sel.ram || sel.vram) begin
        din <= ram_data;
    end else if (sel.rom) begin
        din <= rom_data;
    end else if (sel.char) begin
        din <= char_data;
    end else if (sel.pal) begin
        din <= pal_data;
    end else if (sel.obj) begin
        din <= obj_data;
    end else if (sel.io) begin
        din <= {8'hff, cab_dout}; // byte port on the low lane
    end else begin
        din <= 16'hffff;
    end
end

endmodule

`default_nettype wire

// ==== hw/s16_main.sv ====
`timescale 1ns/1ps
`default_nettype none

module s16_main import s16_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // cpu bus
    input  cpu_bus_t    bus,
    output logic [15:0] din,
    output logic        dtack_n,
    output logic        berr_n,
    output logic        irq_n,
    // cabinet and board
    input  game_t       game,
    input  cab_in_t     cab,
    input  logic        vint,
    input  logic        snd_ack,
    output board_ctrl_t ctrl,
    // memories
    output mem_sel_t    sel,
    input  logic [15:0] char_data,
    input  logic [15:0] pal_data,
    input  logic [15:0] obj_data,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic        rom_ok,
    input  logic        ram_ok
);

logic [7:0] cab_dout;
logic [7:0] ppi_dout;
logic       ppi_cs;

s16_addr_dec u_dec (
    .clk      ( clk       ),
    .rst      ( rst       ),
    .bus      ( bus       ),
    .sel      ( sel       ),
    .berr_n   ( berr_n    )
);

s16_cab_io u_cab (
    .clk      ( clk       ),
    .rst      ( rst       ),
    .io_sel   ( sel.io    ),
    .bus      ( bus       ),
    .game     ( game      ),
    .cab      ( cab       ),
    .ppi_dout ( ppi_dout  ),
    .ppi_cs   ( ppi_cs    ),
    .cab_dout ( cab_dout  )
);

s16_ppi u_ppi (
    .clk      ( clk                      ),
    .rst      ( rst                      ),
    .cs       ( ppi_cs                   ),
    .addr     ( bus.addr[2:1]            ),
    .wr       ( ~(bus.rnw | bus.lds_n)   ), // low byte write
    .din      ( bus.dout[7:0]            ),
    .snd_ack  ( snd_ack                  ),
    .dout     ( ppi_dout                 ),
    .ctrl     ( ctrl                     ),
    .port_b   (                          )  // cab_io reads it back over dout
);

s16_bus_ctrl u_bus (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .bus       ( bus       ),
    .vint      ( vint      ),
    .sel       ( sel       ),
    .rom_ok    ( rom_ok    ),
    .ram_ok    ( ram_ok    ),
    .rom_data  ( rom_data  ),
    .ram_data  ( ram_data  ),
    .char_data ( char_data ),
    .pal_data  ( pal_data  ),
    .obj_data  ( obj_data  ),
    .cab_dout  ( cab_dout  ),
    .dtack_n   ( dtack_n   ),
    .irq_n     ( irq_n     ),
    .din       ( din       )
);

endmodule

`default_nettype wire

// ==== testbench/tb_s16_main.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_s16_main import s16_pkg::*; ();

localparam int cycle_limit = 64; // per wait loop

typedef logic [8*20-1:0] name_t;

logic        clk;
logic        rst;
cpu_bus_t    bus;
logic [15:0] din;
logic        dtack_n, berr_n, irq_n;
game_t       game;
cab_in_t     cab;
logic        vint, snd_ack;
board_ctrl_t ctrl;
mem_sel_t    sel;
logic [15:0] char_data, pal_data, obj_data, rom_data, ram_data;
logic        rom_ok, ram_ok;

int    passes;
int    fails;
int    fd;
int    n_read;
string line;

s16_main DUT (.*);

initial clk = 1'b0;
always #20 clk = ~clk;

// every word differs with the whole byte address
function automatic logic [15:0] mem_word(input logic [15:0] base, input logic [23:0] a);
    return base ^ a[15:0] ^ {a[23:16], 8'h00};
endfunction

// one select per 64 KB page of the memory map
function automatic mem_sel_t page_sel(input logic [23:0] a);
    mem_sel_t s;
    s = '0;
    case (a[23:16])
        8'h00, 8'h01, 8'h02, 8'h03: s.rom = 1'b1;
        8'h40: s.vram = 1'b1;
        8'h41: s.char = 1'b1;
        8'h44: s.obj  = 1'b1;
        8'h84: s.pal  = 1'b1;
        8'hc4: s.io   = 1'b1;
        8'hc6: s.wdog = 1'b1;
        8'hc7: s.ram  = 1'b1;
        default: s = '0; // unmapped
    endcase
    return s;
endfunction

always_comb begin
    rom_data  = mem_word(16'h1000, {bus.addr, 1'b0});
    ram_data  = mem_word(16'h2000, {bus.addr, 1'b0}); // work RAM and VRAM
    char_data = mem_word(16'h3000, {bus.addr, 1'b0});
    pal_data  = mem_word(16'h4000, {bus.addr, 1'b0});
    obj_data  = mem_word(16'h5000, {bus.addr, 1'b0});
end

task automatic log_result(input name_t name, input logic ok, input logic [15:0] exp,
                          input logic [15:0] act);
    if (ok) begin
        passes++;
        $display("[PASS] %0s", name);
    end else begin
        fails++;
        $display("[FAIL] %0s expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_data(input name_t name, input logic [15:0] exp, input logic [15:0] act);
    log_result(name, act === exp, exp, act);
endtask

task automatic check_ctrl(input name_t name, input board_ctrl_t exp, input board_ctrl_t act);
    log_result(name, act === exp, {2'b00, exp}, {2'b00, act});
endtask

task automatic check_berr(input name_t name, input logic exp, input logic act);
    log_result(name, act === exp, {15'd0, exp}, {15'd0, act});
endtask

task automatic check_irq(input name_t name, input logic exp, input logic act);
    log_result(name, act === exp, {15'd0, exp}, {15'd0, act});
endtask

task automatic check_sel(input name_t name, input mem_sel_t exp, input mem_sel_t act,
                         output logic ok);
    ok = act === exp;
    if (!ok) begin
        fails++;
        $display("[FAIL] %0s select expected %b actual %b", name, exp, act);
    end
endtask

// one 68000 word cycle ending on dtack_n or berr_n
task automatic bus_cycle(input logic [23:0] addr, input logic rnw, input logic [15:0] wdata,
                         output logic acked, output logic errd, output logic [15:0] rd,
                         output mem_sel_t sel_now);
    int delay;
    int n;
    delay   = $urandom % 7;
    acked   = 1'b0;
    errd    = 1'b0;
    rd      = 16'hffff;
    sel_now = '0;
    n       = 0;
    @(posedge clk);
    bus.addr  <= addr[23:1];
    bus.rnw   <= rnw;
    bus.dout  <= wdata;
    bus.fc    <= 3'b101; // supervisor data
    bus.uds_n <= 1'b0;
    bus.lds_n <= 1'b0;
    bus.as_n  <= 1'b0;
    rom_ok    <= 1'b0;
    ram_ok    <= 1'b0;
    while (!acked && !errd && n < cycle_limit) begin
        @(negedge clk);
        if (!dtack_n) begin
            acked   = 1'b1;
            rd      = din;
            sel_now = sel;
        end else if (!berr_n) begin
            errd    = 1'b1;
            sel_now = sel;
        end else begin
            @(posedge clk);
            n++;
            if (n >= delay) begin
                rom_ok <= 1'b1;
                ram_ok <= 1'b1;
            end
        end
    end
    if (!acked && !errd) begin
        $display("timeout: no dtack_n or berr_n for address %h", addr);
        fails++;
    end
    @(posedge clk);
    bus.as_n  <= 1'b1;
    bus.uds_n <= 1'b1;
    bus.lds_n <= 1'b1;
    bus.rnw   <= 1'b1;
    repeat (2) @(posedge clk);
endtask

task automatic vblank_test(input name_t name, input logic exp);
    int n;
    n = 0;
    @(posedge clk);
    vint <= 1'b1;
    do begin
        @(negedge clk);
        n++;
    end while (irq_n && n < cycle_limit);
    if (irq_n) begin
        $display("%0s: irq_n stayed high after a rising vint", name);
        fails++;
    end
    @(posedge clk);
    bus.fc   <= 3'b111; // interrupt acknowledge
    bus.as_n <= 1'b0;
    n = 0;
    do begin
        @(negedge clk);
        n++;
    end while (!irq_n && n < cycle_limit);
    if (!irq_n) begin
        $display("%0s: irq_n was not released by the acknowledge", name);
        fails++;
    end
    @(posedge clk);
    bus.as_n <= 1'b1;
    bus.fc   <= 3'b101;
    repeat (8) @(posedge clk); // vint held steady
    @(negedge clk);
    check_irq(name, exp, irq_n);
    @(posedge clk);
    vint <= 1'b0;
endtask

task automatic run_line(input string text);
    name_t       name;
    logic [7:0]  op, game_v, j1, j2, j3, j4, sys_v;
    logic [23:0] addr_v;
    logic [15:0] wdata_v, a1, a2, dips_v, exp_v, rd;
    logic        acked, errd, sel_ok;
    mem_sel_t    sel_v;
    int          n;
    n = $sscanf(text, "%s %s %h %h %h %h %h %h %h %h %h %h %h %h", name, op, game_v,
                addr_v, wdata_v, j1, j2, j3, j4, a1, a2, sys_v, dips_v, exp_v);
    if (n != 14) begin
        $display("trace line could not be parsed: %s", text);
        fails++;
    end else begin
        @(posedge clk);
        game <= game_t'(game_v);
        cab  <= {j1, j2, j3, j4, a1, a2, sys_v, dips_v};
        case (op)
            "c": begin
                @(negedge clk);
                check_ctrl(name, exp_v[13:0], ctrl);
            end
            "r": begin
                bus_cycle(addr_v, 1'b1, wdata_v, acked, errd, rd, sel_v);
                if (errd) begin
                    $display("%0s: bus error on a mapped read", name);
                    fails++;
                end else if (acked) begin
                    check_sel(name, page_sel(addr_v), sel_v, sel_ok);
                    if (sel_ok) check_data(name, exp_v, rd);
                end
            end
            "b": begin
                bus_cycle(addr_v, 1'b1, wdata_v, acked, errd, rd, sel_v);
                if (acked || errd) begin
                    check_sel(name, page_sel(addr_v), sel_v, sel_ok);
                    if (sel_ok) check_berr(name, exp_v[0], !errd);
                end
            end
            "w": begin
                bus_cycle(addr_v, 1'b0, wdata_v, acked, errd, rd, sel_v);
                @(negedge clk);
                if (errd) begin
                    $display("%0s: bus error on a peripheral write", name);
                    fails++;
                end else if (acked) begin
                    check_sel(name, page_sel(addr_v), sel_v, sel_ok);
                    if (sel_ok) check_ctrl(name, exp_v[13:0], ctrl);
                end
            end
            "i": vblank_test(name, exp_v[0]);
            default: begin
                $display("%0s: unknown operation in the trace", name);
                fails++;
            end
        endcase
    end
endtask

initial begin
    void'($urandom(32'hf31e));
    passes    = 0;
    fails     = 0;
    rst       = 1'b1;
    bus       = '0;
    bus.as_n  = 1'b1;
    bus.uds_n = 1'b1;
    bus.lds_n = 1'b1;
    bus.rnw   = 1'b1;
    game      = game_generic;
    cab       = '0;
    vint      = 1'b0;
    snd_ack   = 1'b1;
    rom_ok    = 1'b0;
    ram_ok    = 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    fd = $fopen("testbench/s16_trace.txt", "r");
    if (fd == 0) begin
        $display("the trace file could not be opened");
        fails++;
    end else begin
        while (!$feof(fd)) begin
            n_read = $fgets(line, fd);
            if (n_read > 3 && line.getc(0) != "#") run_line(line); // skip comments
        end
        $fclose(fd);
    end
    $display("tests: %0d passed, %0d failed", passes, fails);
    if (fails == 0) begin
        $display("Done: no errors");
    end else begin
        $display("Done: errors found");
    end
    $finish;
end

endmodule

`default_nettype wire

// ==== testbench/s16_trace.txt ====
# name op(c ctrl, r read, b bus error, w write, i vblank) game addr wdata joy1 joy2 joy3 joy4
# ana1 ana2 sys={start,coin,service,test} dips={dip_a,dip_b} expect (data, board_ctrl or flag)
reset_ctrl     c 0 000000 0000 2d c3 18 46 3c55 8001 a6 5aa5 3fec
rom_read       r 0 012468 0000 2d c3 18 46 3c55 8001 a6 5aa5 3568
char_read      r 0 410ace 0000 2d c3 18 46 3c55 8001 a6 5aa5 7bce
obj_read       r 0 440010 0000 2d c3 18 46 3c55 8001 a6 5aa5 1410
pal_read       r 0 840100 0000 2d c3 18 46 3c55 8001 a6 5aa5 c500
vram_read      r 0 400200 0000 2d c3 18 46 3c55 8001 a6 5aa5 6200
ram_read       r 0 c70020 0000 2d c3 18 46 3c55 8001 a6 5aa5 e720
unmapped_800   b 0 800000 0000 2d c3 18 46 3c55 8001 a6 5aa5 0000
unmapped_040   b 0 040000 0000 2d c3 18 46 3c55 8001 a6 5aa5 0000
gen_port1      r 0 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff74
gen_port3      r 0 c41006 0000 2d c3 18 46 3c55 8001 a6 5aa5 ffc9
dip_a          r 0 c42000 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff5a
dip_b          r 0 c42002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ffa5
ppi_port_a     w 0 c40000 005a 2d c3 18 46 3c55 8001 a6 5aa5 16ac
ppi_port_b     w 1 c40002 0010 2d c3 18 46 3c55 8001 a6 5aa5 16b8
sdi_stick      r 1 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff55
ppi_port_b_neg w 1 c40002 0084 2d c3 18 46 3c55 8001 a6 5aa5 16b4
sdi_stick_neg  r 1 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ffc4
sdi_stick2_neg r 1 c41006 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff80
bsr_irq_clear  w 0 c40006 000e 2d c3 18 46 3c55 8001 a6 5aa5 1694
bsr_col_clear  w 0 c40006 0004 2d c3 18 46 3c55 8001 a6 5aa5 1696
bsr_irq_set    w 0 c40006 000f 2d c3 18 46 3c55 8001 a6 5aa5 16b6
pass_port0     r 2 c41000 0000 2d c3 18 46 3c55 8001 a6 5aa5 ffa9
pass_player1   r 2 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff27
pass_player2   r 2 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ffcc
pass_player3   r 2 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff12
pass_player4   r 2 c41002 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff49
mode_clear     w 0 c40006 0080 2d c3 18 46 3c55 8001 a6 5aa5 0013
ppi_port_c     r 0 c40004 0000 2d c3 18 46 3c55 8001 a6 5aa5 ff40
vblank_irq     i 0 000000 0000 2d c3 18 46 3c55 8001 a6 5aa5 0001

// ==== build.f ====
+incdir+hw
hw/s16_pkg.sv
hw/s16_addr_dec.sv
hw/s16_cab_io.sv
hw/s16_ppi.sv
hw/s16_bus_ctrl.sv
hw/s16_main.sv
testbench/tb_s16_main.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_s16_main
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SRCS := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
